// ==== sim.f ====
common/axi_tap_pkg.sv
common/perf_pkg.sv
perf_monitor/perf_window_fsm.sv
perf_monitor/latency_timer.sv
perf_monitor/event_counters.sv
hdl/axi_perf_top.sv
testbench/tb_axi_perf_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_axi_perf_top -o tb_sim \
    > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1 \
    || { echo "Build or simulation error, see sim.log"; exit 1; }
tail -n 3 sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || echo "Simulation passed"

// ==== testbench/tb_axi_perf_top.sv ====
`timescale 1ns/1ps

module tb_axi_perf_top;
    import axi_tap_pkg::*;
    import perf_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RST_CYCLES   = 5;
    localparam int PRE_CYCLES   = 20;
    localparam int WIN_CYCLES   = 200;
    localparam int STALL_CYCLES = 40;
    localparam int BURST_CYCLES = 100;
    localparam int HOLD_CYCLES  = 20;
    localparam int SHORT_CYCLES = 10;
    // Eleven pulse cycles and five clear checks in the sequence below
    localparam int TOTAL_CYCLES = RST_CYCLES + PRE_CYCLES + 2 * WIN_CYCLES + STALL_CYCLES
                                + 3 * BURST_CYCLES + HOLD_CYCLES + 6 * SHORT_CYCLES + 16;
    localparam int MARGIN       = 100;

    localparam int RDY_RANDOM = 0;
    localparam int RDY_LOW    = 1;
    localparam int RDY_HIGH   = 2;

    logic         clk_i = 1'b0;
    logic         rst_ni;
    logic         start_i;
    logic         stop_i;
    logic         clear_i;
    axi_req_t     axi_req_i;
    axi_rsp_t     axi_rsp_i;
    logic         done_o;
    perf_result_t results_o;

    logic [31:0] rng_state = 32'hfe02_8708;
    int          err_cnt = 0;
    int          chk_cnt = 0;

    // Reference model state
    win_state_e  m_state;
    logic [31:0] m_ar_cnt;
    logic [31:0] m_aw_cnt;
    logic [31:0] m_r_beats;
    logic [31:0] m_b_resps;
    logic [31:0] m_r_stalls;
    logic [31:0] m_b_stalls;
    logic [31:0] m_lat_sum;
    logic [31:0] m_lat_max;
    logic [31:0] m_lat_cnt;
    logic        m_busy;
    axi_id_t     m_id;
    logic [31:0] m_ar_edge;
    logic [31:0] edge_cnt;
    logic [31:0] m_lat;
    logic        ev_ar;
    logic        ev_aw;
    logic        ev_r;
    logic        ev_b;

    axi_perf_top #(.CNT_W(32)) dut_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .start_i   (start_i),
        .stop_i    (stop_i),
        .clear_i   (clear_i),
        .axi_req_i (axi_req_i),
        .axi_rsp_i (axi_rsp_i),
        .done_o    (done_o),
        .results_o (results_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    task automatic zero_model();
        m_ar_cnt   = '0;
        m_aw_cnt   = '0;
        m_r_beats  = '0;
        m_b_resps  = '0;
        m_r_stalls = '0;
        m_b_stalls = '0;
        m_lat_sum  = '0;
        m_lat_max  = '0;
        m_lat_cnt  = '0;
        m_busy     = 1'b0;
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            zero_model();
            m_state  = IDLE;
            edge_cnt = '0;
        end else begin
            edge_cnt = edge_cnt + 32'd1;
            ev_ar = axi_req_i.ar_valid & axi_rsp_i.ar_ready;
            ev_aw = axi_req_i.aw_valid & axi_rsp_i.aw_ready;
            ev_r  = axi_rsp_i.r_valid & axi_req_i.r_ready;
            ev_b  = axi_rsp_i.b_valid & axi_req_i.b_ready;
            if (clear_i) begin
                zero_model();
            end else if (m_state == RUN) begin
                m_ar_cnt   = m_ar_cnt + 32'(ev_ar);
                m_aw_cnt   = m_aw_cnt + 32'(ev_aw);
                m_r_beats  = m_r_beats + 32'(ev_r);
                m_b_resps  = m_b_resps + 32'(ev_b);
                m_r_stalls = m_r_stalls + 32'(axi_rsp_i.r_valid & !axi_req_i.r_ready);
                m_b_stalls = m_b_stalls + 32'(axi_rsp_i.b_valid & !axi_req_i.b_ready);
                // Cycles from the AR edge to the last R edge
                if (m_busy && ev_r && axi_rsp_i.r_last && axi_rsp_i.r_id == m_id) begin
                    m_lat     = edge_cnt - m_ar_edge;
                    m_lat_sum = m_lat_sum + m_lat;
                    m_lat_cnt = m_lat_cnt + 32'd1;
                    if (m_lat > m_lat_max) begin
                        m_lat_max = m_lat;
                    end
                    m_busy = 1'b0;
                end else if (!m_busy && ev_ar) begin
                    m_busy    = 1'b1;
                    m_id      = axi_req_i.ar_id;
                    m_ar_edge = edge_cnt;
                end
            end else begin
                m_busy = 1'b0;
            end
            if (clear_i) begin
                m_state = IDLE;
            end else if (m_state == RUN && stop_i) begin
                m_state = DONE;
            end else if (m_state == IDLE && start_i) begin
                m_state = RUN;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_results(input perf_result_t exp, input logic exp_done);
        chk_cnt++;
        if (done_o !== exp_done) begin
            err_cnt++;
            $display("Fail at %0t ns: done_o is %b, expected %b", $time, done_o, exp_done);
        end
        check_field("ar_cnt", results_o.ar_cnt, exp.ar_cnt);
        check_field("aw_cnt", results_o.aw_cnt, exp.aw_cnt);
        check_field("r_beats", results_o.r_beats, exp.r_beats);
        check_field("b_resps", results_o.b_resps, exp.b_resps);
        check_field("r_stalls", results_o.r_stalls, exp.r_stalls);
        check_field("b_stalls", results_o.b_stalls, exp.b_stalls);
        check_field("lat_sum", results_o.lat_sum, exp.lat_sum);
        check_field("lat_max", results_o.lat_max, exp.lat_max);
        check_field("lat_cnt", results_o.lat_cnt, exp.lat_cnt);
    endtask

    // Every cycle against the model, away from the driving edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            compare_results('{m_ar_cnt, m_aw_cnt, m_r_beats, m_b_resps, m_r_stalls,
                              m_b_stalls, m_lat_sum, m_lat_max, m_lat_cnt}, m_state == DONE);
        end
    end

    // Fixed expectation of all zero, independent of the model
    // One idle step lets the edge that samples the clear pass first
    task automatic expect_cleared();
        step(1'b0, 1'b0, 1'b0, RDY_RANDOM, 4'hf);
        @(negedge clk_i);
        compare_results('0, 1'b0);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic step(input logic start, input logic stop, input logic clear,
                        input int ready_mode, input logic [3:0] id_mask);
        axi_req_t    req;
        axi_rsp_t    rsp;
        logic [31:0] r;
        rng_state    = xorshift32(rng_state);
        r            = rng_state;
        req.ar_valid = r[0];
        req.ar_id    = r[4:1] & id_mask;
        req.aw_valid = r[5];
        req.r_ready  = r[6];
        req.b_ready  = r[7];
        rsp.ar_ready = r[8];
        rsp.aw_ready = r[9];
        rsp.r_valid  = r[10] | r[11];
        rsp.r_id     = r[15:12] & id_mask;
        rsp.r_last   = r[16];
        rsp.b_valid  = r[17];
        if (ready_mode == RDY_LOW) begin
            req.r_ready = 1'b0;
            req.b_ready = 1'b0;
        end else if (ready_mode == RDY_HIGH) begin
            req.r_ready = r[6] | r[18] | r[19];
            req.b_ready = r[7] | r[20] | r[21];
        end
        @(posedge clk_i);
        start_i   <= start;
        stop_i    <= stop;
        clear_i   <= clear;
        axi_req_i <= req;
        axi_rsp_i <= rsp;
    endtask

    task automatic traffic(input int n, input int ready_mode, input logic [3:0] id_mask);
        repeat (n) step(1'b0, 1'b0, 1'b0, ready_mode, id_mask);
    endtask

    initial begin
        rst_ni    <= 1'b0;
        start_i   <= 1'b0;
        stop_i    <= 1'b0;
        clear_i   <= 1'b0;
        axi_req_i <= '0;
        axi_rsp_i <= '0;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        expect_cleared();

        // Idle traffic, then a long first window
        traffic(PRE_CYCLES, RDY_RANDOM, 4'hf);
        step(1'b1, 1'b0, 1'b0, RDY_RANDOM, 4'h3);
        traffic(WIN_CYCLES, RDY_RANDOM, 4'h3);
        traffic(STALL_CYCLES, RDY_LOW, 4'h3);
        traffic(BURST_CYCLES, RDY_HIGH, 4'h3);
        step(1'b0, 1'b1, 1'b0, RDY_RANDOM, 4'h3);

        // Hold in DONE, start is ignored there
        traffic(HOLD_CYCLES, RDY_RANDOM, 4'hf);
        step(1'b1, 1'b0, 1'b0, RDY_RANDOM, 4'hf);
        traffic(SHORT_CYCLES, RDY_RANDOM, 4'hf);
        if (m_lat_cnt == 0 || m_r_stalls == 0) begin
            err_cnt++;
            $display("First window timed no read or saw no read stall");
        end

        // Clear in DONE
        step(1'b0, 1'b0, 1'b1, RDY_RANDOM, 4'hf);
        expect_cleared();
        traffic(SHORT_CYCLES, RDY_RANDOM, 4'hf);

        // Clear while RUN drops the open measurement
        step(1'b1, 1'b0, 1'b0, RDY_RANDOM, 4'hf);
        traffic(WIN_CYCLES, RDY_RANDOM, 4'hf);
        step(1'b0, 1'b0, 1'b1, RDY_RANDOM, 4'hf);
        expect_cleared();
        traffic(SHORT_CYCLES, RDY_RANDOM, 4'h3);

        // Clear wins over a stop in the same cycle
        step(1'b1, 1'b0, 1'b0, RDY_RANDOM, 4'h3);
        traffic(BURST_CYCLES, RDY_HIGH, 4'h3);
        step(1'b0, 1'b1, 1'b1, RDY_RANDOM, 4'h3);
        expect_cleared();
        traffic(SHORT_CYCLES, RDY_RANDOM, 4'h3);

        // Clear in IDLE
        step(1'b0, 1'b0, 1'b1, RDY_RANDOM, 4'h3);
        expect_cleared();
        traffic(SHORT_CYCLES, RDY_RANDOM, 4'h3);

        // Last window counts from zero
        step(1'b1, 1'b0, 1'b0, RDY_RANDOM, 4'h3);
        traffic(BURST_CYCLES, RDY_RANDOM, 4'h3);
        step(1'b0, 1'b1, 1'b0, RDY_RANDOM, 4'h3);
        traffic(SHORT_CYCLES, RDY_RANDOM, 4'hf);
        @(negedge clk_i);

        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN));
        $display("Watchdog expired before the test sequence finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== hdl/axi_perf_top.sv ====
`timescale 1ns/1ps

module axi_perf_top #(
    parameter int unsigned CNT_W = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   start_i,
    input  logic                   stop_i,
    input  logic                   clear_i,
    input  axi_tap_pkg::axi_req_t  axi_req_i,
    input  axi_tap_pkg::axi_rsp_t  axi_rsp_i,
    output logic                   done_o,
    output perf_pkg::perf_result_t results_o
);
    import perf_pkg::*;

    logic             run;
    logic             clear;
    logic [CNT_W-1:0] ar_cnt;
    logic [CNT_W-1:0] aw_cnt;
    logic [CNT_W-1:0] r_beats;
    logic [CNT_W-1:0] b_resps;
    logic [CNT_W-1:0] r_stalls;
    logic [CNT_W-1:0] b_stalls;
    logic [CNT_W-1:0] lat_sum;
    logic [CNT_W-1:0] lat_max;
    logic [CNT_W-1:0] lat_cnt;

    // Counters must fit the reported fields
    if (CNT_W > RES_W) begin : g_width_check
        $error("CNT_W exceeds result field width");
    end

    perf_window_fsm u_window (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (start_i),
        .stop_i  (stop_i),
        .clear_i (clear_i),
        .run_o   (run),
        .clear_o (clear),
        .done_o  (done_o)
    );

    latency_timer #(.CNT_W(CNT_W)) u_latency (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .run_i     (run),
        .clear_i   (clear),
        .axi_req_i (axi_req_i),
        .axi_rsp_i (axi_rsp_i),
        .lat_sum_o (lat_sum),
        .lat_max_o (lat_max),
        .lat_cnt_o (lat_cnt)
    );

    event_counters #(.CNT_W(CNT_W)) u_events (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .run_i      (run),
        .clear_i    (clear),
        .axi_req_i  (axi_req_i),
        .axi_rsp_i  (axi_rsp_i),
        .ar_cnt_o   (ar_cnt),
        .aw_cnt_o   (aw_cnt),
        .r_beats_o  (r_beats),
        .b_resps_o  (b_resps),
        .r_stalls_o (r_stalls),
        .b_stalls_o (b_stalls)
    );

    ////////////////////
    // Result bundle
    ////////////////////

    // Zero extended to the fixed field width
    always_comb begin
        results_o.ar_cnt   = RES_W'(ar_cnt);
        results_o.aw_cnt   = RES_W'(aw_cnt);
        results_o.r_beats  = RES_W'(r_beats);
        results_o.b_resps  = RES_W'(b_resps);
        results_o.r_stalls = RES_W'(r_stalls);
        results_o.b_stalls = RES_W'(b_stalls);
        results_o.lat_sum  = RES_W'(lat_sum);
        results_o.lat_max  = RES_W'(lat_max);
        results_o.lat_cnt  = RES_W'(lat_cnt);
    end

endmodule

// ==== perf_monitor/event_counters.sv ====
`timescale 1ns/1ps

module event_counters #(
    parameter int unsigned CNT_W = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  run_i,
    input  logic                  clear_i,
    input  axi_tap_pkg::axi_req_t axi_req_i,
    input  axi_tap_pkg::axi_rsp_t axi_rsp_i,
    output logic [CNT_W-1:0]      ar_cnt_o,
    output logic [CNT_W-1:0]      aw_cnt_o,
    output logic [CNT_W-1:0]      r_beats_o,
    output logic [CNT_W-1:0]      b_resps_o,
    output logic [CNT_W-1:0]      r_stalls_o,
    output logic [CNT_W-1:0]      b_stalls_o
);
    import perf_pkg::*;

    perf_events_t ev;

    ////////////////////
    // Event decode
    ////////////////////

    always_comb begin
        ev.ar_hs   = axi_req_i.ar_valid && axi_rsp_i.ar_ready;
        ev.aw_hs   = axi_req_i.aw_valid && axi_rsp_i.aw_ready;
        ev.r_hs    = axi_rsp_i.r_valid && axi_req_i.r_ready;
        ev.b_hs    = axi_rsp_i.b_valid && axi_req_i.b_ready;
        // Slave has data, master holds off
        ev.r_stall = axi_rsp_i.r_valid && !axi_req_i.r_ready;
        ev.b_stall = axi_rsp_i.b_valid && !axi_req_i.b_ready;
    end

    ////////////////////
    // Counters
    ////////////////////

    // Clear wins over counting, counters wrap at CNT_W
    always_ff @(posedge clk_i) begin
        if (!rst_ni || clear_i) begin
            ar_cnt_o   <= '0;
            aw_cnt_o   <= '0;
            r_beats_o  <= '0;
            b_resps_o  <= '0;
            r_stalls_o <= '0;
            b_stalls_o <= '0;
        end else if (run_i) begin
            ar_cnt_o   <= ar_cnt_o + CNT_W'(ev.ar_hs);
            aw_cnt_o   <= aw_cnt_o + CNT_W'(ev.aw_hs);
            r_beats_o  <= r_beats_o + CNT_W'(ev.r_hs);
            b_resps_o  <= b_resps_o + CNT_W'(ev.b_hs);
            r_stalls_o <= r_stalls_o + CNT_W'(ev.r_stall);
            b_stalls_o <= b_stalls_o + CNT_W'(ev.b_stall);
        end
    end

    // A cycle is either a handshake or a stall on a channel, never both
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ev.r_hs && ev.r_stall) && !(ev.b_hs && ev.b_stall));

endmodule

// ==== perf_monitor/latency_timer.sv ====
`timescale 1ns/1ps

module latency_timer #(
    parameter int unsigned CNT_W = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  run_i,
    input  logic                  clear_i,
    input  axi_tap_pkg::axi_req_t axi_req_i,
    input  axi_tap_pkg::axi_rsp_t axi_rsp_i,
    output logic [CNT_W-1:0]      lat_sum_o,
    output logic [CNT_W-1:0]      lat_max_o,
    output logic [CNT_W-1:0]      lat_cnt_o
);
    import axi_tap_pkg::*;

    logic             busy_q;
    axi_id_t          id_q;
    logic [CNT_W-1:0] timer_q;
    logic             ar_take;
    logic             r_done;

    // New measurement only when idle and inside the window
    assign ar_take = run_i && !busy_q && axi_req_i.ar_valid && axi_rsp_i.ar_ready;

    // Ends on the last beat of the captured ID only
    assign r_done = run_i && busy_q && axi_rsp_i.r_valid && axi_req_i.r_ready
                  && axi_rsp_i.r_last && (axi_rsp_i.r_id == id_q);

    ////////////////////
    // Tracker
    ////////////////////

    // Leaving RUN drops an open transaction
    always_ff @(posedge clk_i) begin
        if (!rst_ni || clear_i || !run_i) begin
            busy_q <= 1'b0;
        end else if (ar_take) begin
            busy_q <= 1'b1;
        end else if (r_done) begin
            busy_q <= 1'b0;
        end
    end

    // Timer reads 1 in the cycle after the AR handshake
    always_ff @(posedge clk_i) begin
        if (ar_take) begin
            id_q    <= axi_req_i.ar_id;
            timer_q <= CNT_W'(1);
        end else if (busy_q) begin
            timer_q <= timer_q + CNT_W'(1);
        end
    end

    ////////////////////
    // Statistics
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni || clear_i) begin
            lat_sum_o <= '0;
            lat_max_o <= '0;
            lat_cnt_o <= '0;
        end else if (r_done) begin
            lat_sum_o <= lat_sum_o + timer_q;
            lat_cnt_o <= lat_cnt_o + CNT_W'(1);
            if (timer_q > lat_max_o) begin
                lat_max_o <= timer_q;
            end
        end
    end

    // Timer starts at 1, so zero while busy means it wrapped
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        busy_q |-> timer_q != '0);

endmodule

// ==== perf_monitor/perf_window_fsm.sv ====
`timescale 1ns/1ps

module perf_window_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic start_i,
    input  logic stop_i,
    input  logic clear_i,
    output logic run_o,
    output logic clear_o,
    output logic done_o
);
    import perf_pkg::*;

    win_state_e state_q;
    win_state_e state_d;
    logic       clear_q;

    // Next state, clear beats stop beats start
    always_comb begin
        state_d = state_q;
        if (clear_i) begin
            state_d = IDLE;
        end else if (stop_i && state_q == RUN) begin
            state_d = DONE;
        end else if (start_i && state_q == IDLE) begin
            state_d = RUN;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            clear_q <= 1'b0;
        end else begin
            state_q <= state_d;
            clear_q <= clear_i;
        end
    end

    assign run_o  = (state_q == RUN);
    assign done_o = (state_q == DONE);

    // One cycle clear, even if the request is held
    assign clear_o = clear_i && !clear_q;

    ////////////////////
    // Checks
    ////////////////////

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(run_o && done_o));

endmodule

// ==== common/perf_pkg.sv ====
package perf_pkg;

    ////////////////////
    // Window control
    ////////////////////

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } win_state_e;

    ////////////////////
    // Events and results
    ////////////////////

    // One cycle strobes, decoded from the tapped channels
    typedef struct packed {
        logic ar_hs;
        logic aw_hs;
        logic r_hs;
        logic b_hs;
        logic r_stall;
        logic b_stall;
    } perf_events_t;

    // Reported field width, counters narrower than this are zero extended
    localparam int unsigned RES_W = 32;

    typedef struct packed {
        logic [RES_W-1:0] ar_cnt;
        logic [RES_W-1:0] aw_cnt;
        logic [RES_W-1:0] r_beats;
        logic [RES_W-1:0] b_resps;
        logic [RES_W-1:0] r_stalls;
        logic [RES_W-1:0] b_stalls;
        logic [RES_W-1:0] lat_sum;
        logic [RES_W-1:0] lat_max;
        logic [RES_W-1:0] lat_cnt;
    } perf_result_t;

endpackage

// ==== common/axi_tap_pkg.sv ====
package axi_tap_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Transaction ID width on AR and R
    localparam int unsigned AXI_ID_W = 4;

    typedef logic [AXI_ID_W-1:0] axi_id_t;

    ////////////////////
    // Tapped channels
    ////////////////////

    // Master side control fields
    // Only what the monitor needs, no payloads and no W channel
    typedef struct packed {
        logic    ar_valid;
        axi_id_t ar_id;
        logic    aw_valid;
        logic    r_ready;
        logic    b_ready;
    } axi_req_t;

    // Slave side control fields
    typedef struct packed {
        logic    ar_ready;
        logic    aw_ready;
        logic    r_valid;
        axi_id_t r_id;
        // Last beat of a read burst
        logic    r_last;
        logic    b_valid;
    } axi_rsp_t;

endpackage
